//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= lsu_tb
RTL_TOP    ?= lsu_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/lsu_tb.sv
// lsu testbench: random load/store traffic checked against a shadow memory reference model
`timescale 1ns/10ps

module lsu_tb import lsu_pkg::*; ();

    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned MEM_DW       = 16;
    localparam int unsigned GNT_PCT      = 60;
    localparam int unsigned N_LOADS      = 24;
    localparam int unsigned N_PAIRS      = 12;
    localparam int unsigned N_MISALIGNED = 16;
    localparam int unsigned N_RANDOM     = 60;
    localparam int unsigned TOTAL_OPS    = N_LOADS + 4 * N_PAIRS + N_MISALIGNED + N_RANDOM;
    localparam logic [31:0] SEED         = 32'h7774c217;

    // expected writeback of one operation
    typedef struct packed {
        trans_id_t id;
        logic      ex;
        cause_t    cause;
        addr_t     tval;
        xlen_t     value;
    } wb_exp_t;

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      lsu_valid_i;
    lsu_op_e   op_i;
    xlen_t     operand_a_i;
    xlen_t     operand_b_i;
    xlen_t     imm_i;
    trans_id_t trans_id_i;
    logic      lsu_ready_o;
    logic      load_valid_o;
    trans_id_t load_trans_id_o;
    xlen_t     load_result_o;
    logic      load_ex_valid_o;
    cause_t    load_ex_cause_o;
    addr_t     load_ex_tval_o;
    logic      store_valid_o;
    trans_id_t store_trans_id_o;
    xlen_t     store_result_o;
    logic      store_ex_valid_o;
    cause_t    store_ex_cause_o;
    addr_t     store_ex_tval_o;
    logic      mem_req_o;
    logic      mem_we_o;
    addr_t     mem_addr_o;
    xlen_t     mem_wdata_o;
    be_t       mem_be_o;
    logic      mem_gnt_i    = 1'b0;
    logic      mem_rvalid_i = 1'b0;
    xlen_t     mem_rdata_i  = '0;

    xlen_t       mem [MEM_DW];
    xlen_t       shadow [MEM_DW];
    logic [3:0]  mem_idx;
    wb_exp_t     ld_exp_q [$];
    wb_exp_t     st_exp_q [$];
    trans_id_t   next_id;
    string       test_name;
    int unsigned test_checks;
    int unsigned test_errors;
    int unsigned total_checks;
    int unsigned total_errors;
    int unsigned n_tests;

    lsu_top uut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .lsu_valid_i      (lsu_valid_i),
        .op_i             (op_i),
        .operand_a_i      (operand_a_i),
        .operand_b_i      (operand_b_i),
        .imm_i            (imm_i),
        .trans_id_i       (trans_id_i),
        .lsu_ready_o      (lsu_ready_o),
        .load_valid_o     (load_valid_o),
        .load_trans_id_o  (load_trans_id_o),
        .load_result_o    (load_result_o),
        .load_ex_valid_o  (load_ex_valid_o),
        .load_ex_cause_o  (load_ex_cause_o),
        .load_ex_tval_o   (load_ex_tval_o),
        .store_valid_o    (store_valid_o),
        .store_trans_id_o (store_trans_id_o),
        .store_result_o   (store_result_o),
        .store_ex_valid_o (store_ex_valid_o),
        .store_ex_cause_o (store_ex_cause_o),
        .store_ex_tval_o  (store_ex_tval_o),
        .mem_req_o        (mem_req_o),
        .mem_we_o         (mem_we_o),
        .mem_addr_o       (mem_addr_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_be_o         (mem_be_o),
        .mem_gnt_i        (mem_gnt_i),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ----------------------------------------
    // reference model helpers
    // ----------------------------------------
    function automatic int unsigned bytes_of(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic logic is_write_op(input lsu_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    // odd multiplier keeps every byte address distinct
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 59 + 23);
    endfunction

    function automatic xlen_t random_data();
        return {$urandom, $urandom};
    endfunction

    function automatic addr_t pick_addr(input int unsigned nbytes, input bit aligned);
        int unsigned dw;
        int unsigned off;
        dw  = $urandom % MEM_DW;
        off = $urandom % 8;
        if (aligned) begin
            off = off - (off % nbytes);
        end else if (off % nbytes == 0) begin
            off = off + 1;
        end
        return addr_t'(dw * 8 + off);
    endfunction

    function automatic xlen_t predict_load(input lsu_op_e op, input addr_t addr);
        int unsigned nbytes;
        int unsigned off;
        xlen_t       dw;
        xlen_t       val;
        nbytes = bytes_of(op);
        off    = int'(addr[2:0]);
        dw     = shadow[addr[6:3]];
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = dw[8*(off+i) +: 8];
        end
        // signed loads copy the top loaded bit upward
        if (op inside {LB, LH, LW} && val[8*nbytes-1]) begin
            for (int i = nbytes; i < 8; i++) begin
                val[8*i +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    task automatic apply_store(input lsu_op_e op, input addr_t addr, input xlen_t data);
        int unsigned off;
        off = int'(addr[2:0]);
        for (int i = 0; i < bytes_of(op); i++) begin
            shadow[addr[6:3]][8*(off+i) +: 8] = data[8*i +: 8];
        end
    endtask

    task automatic check_value(input string what, input xlen_t want, input xlen_t got);
        test_checks++;
        assert (want === got) else begin
            $display("Fail %s (%s): expected %h, actual %h", test_name, what, want, got);
            test_errors++;
        end
    endtask

    task automatic check_writeback(input string stream, input wb_exp_t want,
                                   input trans_id_t id, input logic ex, input cause_t cause,
                                   input addr_t tval, input xlen_t result);
        check_value({stream, " trans_id"}, xlen_t'(want.id), xlen_t'(id));
        check_value({stream, " exception"}, xlen_t'(want.ex), xlen_t'(ex));
        if (want.ex) begin
            check_value({stream, " cause"}, xlen_t'(want.cause), xlen_t'(cause));
            check_value({stream, " tval"}, xlen_t'(want.tval), xlen_t'(tval));
        end else begin
            check_value({stream, " result"}, want.value, result);
        end
    endtask

    // ----------------------------------------
    // memory model
    // ----------------------------------------
    always @(posedge clk_i) begin
        mem_rvalid_i <= 1'b0;
        if (!rst_ni) begin
            for (int a = 0; a < MEM_DW * 8; a++) begin
                mem[4'(a >> 3)][8*(a%8) +: 8] = fill_byte(a);
            end
        end else if (mem_req_o && mem_gnt_i) begin
            assert (mem_addr_o < addr_t'(MEM_DW * 8) && mem_addr_o[2:0] == 3'b000) else begin
                $display("memory request to an address outside the model: %h", mem_addr_o);
                test_errors++;
            end
            mem_idx = mem_addr_o[6:3];
            if (mem_we_o) begin
                for (int b = 0; b < 8; b++) begin
                    if (mem_be_o[b]) begin
                        mem[mem_idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
                    end
                end
            end else begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= mem[mem_idx];
            end
        end
        mem_gnt_i <= ($urandom % 100) < GNT_PCT;
    end

    // writebacks come back in order within each stream
    always @(posedge clk_i) begin : writeback_monitor
        wb_exp_t want;
        if (rst_ni && load_valid_o) begin
            assert (ld_exp_q.size() != 0) else begin
                $display("load writeback with no load pending, trans_id %0d", load_trans_id_o);
                test_errors++;
            end
            if (ld_exp_q.size() != 0) begin
                want = ld_exp_q.pop_front();
                check_writeback("load", want, load_trans_id_o, load_ex_valid_o,
                                load_ex_cause_o, load_ex_tval_o, load_result_o);
            end
        end
        if (rst_ni && store_valid_o) begin
            assert (st_exp_q.size() != 0) else begin
                $display("store writeback with no store pending, trans_id %0d", store_trans_id_o);
                test_errors++;
            end
            if (st_exp_q.size() != 0) begin
                want = st_exp_q.pop_front();
                check_writeback("store", want, store_trans_id_o, store_ex_valid_o,
                                store_ex_cause_o, store_ex_tval_o, store_result_o);
            end
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic issue_op(input lsu_op_e op, input addr_t addr, input xlen_t data);
        int signed imm_s;
        xlen_t     imm;
        wb_exp_t   want;
        // a quiet cycle with an empty queue keeps the next one empty too
        do begin
            @(posedge clk_i);
        end while (lsu_valid_i || !lsu_ready_o);
        imm_s = int'($urandom % 128) - 64;
        imm   = xlen_t'(imm_s);
        lsu_valid_i <= 1'b1;
        op_i        <= op;
        operand_a_i <= xlen_t'(addr) - imm;
        operand_b_i <= data;
        imm_i       <= imm;
        trans_id_i  <= next_id;
        want.id    = next_id;
        want.ex    = (addr % bytes_of(op)) != 0;
        want.cause = is_write_op(op) ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        want.tval  = addr;
        want.value = '0;
        if (!want.ex && is_write_op(op)) begin
            apply_store(op, addr, data);
        end else if (!want.ex) begin
            want.value = predict_load(op, addr);
        end
        if (is_write_op(op)) begin
            st_exp_q.push_back(want);
        end else begin
            ld_exp_q.push_back(want);
        end
        next_id = next_id + 1'b1;
        @(posedge clk_i);
        lsu_valid_i <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        while (ld_exp_q.size() != 0 || st_exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);
        for (int i = 0; i < MEM_DW; i++) begin
            check_value($sformatf("memory doubleword %0d", i), shadow[i], mem[i]);
        end
        $display("%-16s %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        n_tests++;
    endtask

    task automatic run_aligned_loads();
        lsu_op_e op;
        start_test("aligned_loads");
        for (int i = 0; i < N_LOADS; i++) begin
            op = lsu_op_e'(4'(i % 7));
            issue_op(op, pick_addr(bytes_of(op), 1'b1), random_data());
        end
        finish_test();
    endtask

    task automatic run_store_readback();
        lsu_op_e op;
        addr_t   addr;
        start_test("store_readback");
        for (int i = 0; i < N_PAIRS; i++) begin
            op   = lsu_op_e'(4'(7 + i % 4));
            addr = pick_addr(bytes_of(op), 1'b1);
            issue_op(op, addr, random_data());
            issue_op(LD, {addr[ADDR_W-1:3], 3'b000}, random_data());
        end
        finish_test();
    endtask

    task automatic run_misaligned();
        lsu_op_e op;
        start_test("misaligned");
        for (int i = 0; i < N_MISALIGNED; i++) begin
            do begin
                op = lsu_op_e'(4'($urandom % 11));
            end while (bytes_of(op) == 1);
            issue_op(op, pick_addr(bytes_of(op), 1'b0), random_data());
        end
        finish_test();
    endtask

    task automatic run_store_then_load();
        lsu_op_e st_op;
        lsu_op_e ld_op;
        addr_t   st_addr;
        start_test("store_then_load");
        for (int i = 0; i < N_PAIRS; i++) begin
            st_op   = lsu_op_e'(4'(7 + $urandom % 4));
            ld_op   = lsu_op_e'(4'($urandom % 7));
            st_addr = pick_addr(bytes_of(st_op), 1'b1);
            issue_op(st_op, st_addr, random_data());
            // load overlaps the stored bytes
            issue_op(ld_op, st_addr & ~addr_t'(bytes_of(ld_op) - 1), random_data());
        end
        finish_test();
    endtask

    task automatic run_random_mix();
        lsu_op_e op;
        bit      aligned;
        start_test("random_mix");
        for (int i = 0; i < N_RANDOM; i++) begin
            op      = lsu_op_e'(4'($urandom % 11));
            aligned = (bytes_of(op) == 1) || (($urandom % 100) < 85);
            repeat ($urandom % 3) @(posedge clk_i);
            issue_op(op, pick_addr(bytes_of(op), aligned), random_data());
        end
        finish_test();
    endtask

    initial begin : main
        void'($urandom(SEED));
        rst_ni       = 1'b0;
        lsu_valid_i  = 1'b0;
        op_i         = LB;
        operand_a_i  = '0;
        operand_b_i  = '0;
        imm_i        = '0;
        trans_id_i   = '0;
        next_id      = '0;
        total_checks = 0;
        total_errors = 0;
        n_tests      = 0;
        for (int a = 0; a < MEM_DW * 8; a++) begin
            shadow[4'(a >> 3)][8*(a%8) +: 8] = fill_byte(a);
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        start_test("reset");
        @(posedge clk_i);
        check_value("ready", 64'd1, xlen_t'(lsu_ready_o));
        check_value("mem_req", 64'd0, xlen_t'(mem_req_o));
        check_value("load_valid", 64'd0, xlen_t'(load_valid_o));
        check_value("store_valid", 64'd0, xlen_t'(store_valid_o));
        finish_test();
        run_aligned_loads();
        run_store_readback();
        run_misaligned();
        run_store_then_load();
        run_random_mix();
        $display("tests %0d, checks %0d, errors %0d", n_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + TOTAL_OPS * 40) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d cycles",
                 RESET_CYCLES + TOTAL_OPS * 40);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- flist.f
hw/lsu_pkg.sv
hw/mem_req_if.sv
hw/lsu_issue.sv
hw/load_unit.sv
hw/store_unit.sv
hw/mem_arbiter.sv
hw/lsu_top.sv
dv/lsu_tb.sv

//--- hw/load_unit.sv
// load unit: single outstanding load with store hazard wait, memory read and extension
`timescale 1ns/10ps

module load_unit import lsu_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             valid_i,
    input  lsu_ctrl_t        ctrl_i,
    input  logic             addr_match_i,
    output logic             pop_o,
    output addr_t            dw_addr_o,
    mem_req_if.unit_mp       mem,
    output logic             valid_o,
    output trans_id_t        trans_id_o,
    output xlen_t            result_o,
    output logic             ex_valid_o,
    output cause_t           ex_cause_o,
    output addr_t            ex_tval_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_HAZARD,
        WAIT_GNT,
        WAIT_RVALID,
        EX
    } ld_state_e;

    ld_state_e state_q;
    ld_state_e state_d;
    lsu_ctrl_t ld_q;
    logic      take;
    logic      rd_done;
    logic      done_q;
    xlen_t     rdata_sh;
    xlen_t     ext;
    xlen_t     result_q;

    // doubleword of the offered load, compared against the held store
    assign dw_addr_o = {ctrl_i.addr[ADDR_W-1:DW_OFF_W], {DW_OFF_W{1'b0}}};

    assign take    = valid_i && !addr_match_i && (state_q == IDLE || state_q == WAIT_HAZARD);
    assign pop_o   = take;
    assign rd_done = (state_q == WAIT_RVALID) && mem.rvalid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, WAIT_HAZARD: begin
                if (take) begin
                    state_d = ctrl_i.misaligned ? EX : WAIT_GNT;
                end else if (valid_i) begin
                    state_d = WAIT_HAZARD;
                end else begin
                    state_d = IDLE;
                end
            end
            WAIT_GNT:    if (mem.gnt) state_d = WAIT_RVALID;
            WAIT_RVALID: if (mem.rvalid) state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    // ----------------------------------------
    // result extraction
    // ----------------------------------------
    assign rdata_sh = mem.rdata >> {ld_q.addr[DW_OFF_W-1:0], 3'b000};

    always_comb begin
        case (ld_q.op)
            LB:      ext = {{(XLEN_W-8){rdata_sh[7]}}, rdata_sh[7:0]};
            LBU:     ext = {{(XLEN_W-8){1'b0}}, rdata_sh[7:0]};
            LH:      ext = {{(XLEN_W-16){rdata_sh[15]}}, rdata_sh[15:0]};
            LHU:     ext = {{(XLEN_W-16){1'b0}}, rdata_sh[15:0]};
            LW:      ext = {{(XLEN_W-32){rdata_sh[31]}}, rdata_sh[31:0]};
            LWU:     ext = {{(XLEN_W-32){1'b0}}, rdata_sh[31:0]};
            default: ext = rdata_sh;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= rd_done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            ld_q <= ctrl_i;
        end
        if (rd_done) begin
            result_q <= ext;
        end
    end

    // memory read of the whole doubleword
    assign mem.req   = (state_q == WAIT_GNT);
    assign mem.we    = 1'b0;
    assign mem.addr  = {ld_q.addr[ADDR_W-1:DW_OFF_W], {DW_OFF_W{1'b0}}};
    assign mem.wdata = '0;
    assign mem.be    = ld_q.be;

    // writeback
    assign valid_o    = done_q | (state_q == EX);
    assign trans_id_o = ld_q.trans_id;
    assign result_o   = (state_q == EX) ? '0 : result_q;
    assign ex_valid_o = (state_q == EX);
    assign ex_cause_o = CAUSE_LD_MISALIGNED;
    assign ex_tval_o  = ld_q.addr;

endmodule

//--- hw/lsu_issue.sv
// lsu issue stage: address generation, byte enables, misalignment check and bypass queue
`timescale 1ns/10ps

module lsu_issue import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      lsu_valid_i,
    input  lsu_op_e   op_i,
    input  xlen_t     operand_a_i,
    input  xlen_t     operand_b_i,
    input  xlen_t     imm_i,
    input  trans_id_t trans_id_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output logic      lsu_ready_o,
    output lsu_ctrl_t ctrl_o,
    output logic      ld_valid_o,
    output logic      st_valid_o
);

    xlen_t      vaddr;
    addr_t      addr;
    logic [3:0] size;
    be_t        be;
    logic       misaligned;
    lsu_ctrl_t  req;

    lsu_ctrl_t  mem_q [2];
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic [1:0] cnt_q;
    logic       empty;
    logic       pop;

    // ----------------------------------------
    // address generation
    // ----------------------------------------
    // two's complement add covers the signed immediate
    assign vaddr = operand_a_i + imm_i;
    assign addr  = vaddr[ADDR_W-1:0];
    assign size  = op_size(op_i);

    // byte lanes of the access within its doubleword
    always_comb begin
        case (size)
            4'd1:    be = be_t'(8'h01) << addr[DW_OFF_W-1:0];
            4'd2:    be = be_t'(8'h03) << addr[DW_OFF_W-1:0];
            4'd4:    be = be_t'(8'h0f) << addr[DW_OFF_W-1:0];
            default: be = be_t'(8'hff);
        endcase
    end

    // offset must be a multiple of the size, size 8 wraps to mask 7
    assign misaligned = |(addr[DW_OFF_W-1:0] & (size[DW_OFF_W-1:0] - 3'd1));

    always_comb begin
        req.valid      = lsu_valid_i;
        req.is_store   = op_is_store(op_i);
        req.addr       = addr;
        req.data       = operand_b_i;
        req.be         = be;
        req.op         = op_i;
        req.trans_id   = trans_id_i;
        req.misaligned = misaligned;
    end

    // ----------------------------------------
    // bypass queue
    // ----------------------------------------
    assign empty       = (cnt_q == 2'd0);
    assign pop         = pop_ld_i | pop_st_i;
    assign lsu_ready_o = empty;

    // incoming request goes straight through when nothing is queued
    assign ctrl_o = empty ? req : mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (lsu_valid_i) begin
            mem_q[wr_ptr_q] <= req;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (lsu_valid_i) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({lsu_valid_i, pop})
                2'b10:   cnt_q <= cnt_q + 2'd1;
                2'b01:   cnt_q <= cnt_q - 2'd1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // ----------------------------------------
    // dispatch
    // ----------------------------------------
    assign ld_valid_o = ctrl_o.valid & ~ctrl_o.is_store;
    assign st_valid_o = ctrl_o.valid & ctrl_o.is_store;

endmodule

//--- hw/lsu_pkg.sv
// lsu shared definitions: widths, operation encoding, control struct and size helpers
package lsu_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int unsigned XLEN_W     = 64;
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned TRANS_ID_W = 3;
    localparam int unsigned BE_W       = 8;
    // byte offset bits inside one doubleword
    localparam int unsigned DW_OFF_W   = 3;

    typedef logic [XLEN_W-1:0]     xlen_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [TRANS_ID_W-1:0] trans_id_t;
    typedef logic [BE_W-1:0]       be_t;

    // ----------------------------------------
    // exception causes
    // ----------------------------------------
    typedef logic [3:0] cause_t;

    localparam cause_t CAUSE_LD_MISALIGNED = 4'd4;
    localparam cause_t CAUSE_ST_MISALIGNED = 4'd6;

    // ----------------------------------------
    // operations
    // ----------------------------------------
    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWU,
        LD,
        SB,
        SH,
        SW,
        SD
    } lsu_op_e;

    // one operation as it moves through the bypass queue
    typedef struct packed {
        logic      valid;
        logic      is_store;
        addr_t     addr;
        xlen_t     data;
        be_t       be;
        lsu_op_e   op;
        trans_id_t trans_id;
        logic      misaligned;
    } lsu_ctrl_t;

    // access size in bytes
    function automatic logic [3:0] op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 4'd1;
            LH, LHU, SH: return 4'd2;
            LW, LWU, SW: return 4'd4;
            default:     return 4'd8;
        endcase
    endfunction

    function automatic logic op_is_store(lsu_op_e op);
        case (op)
            SB, SH, SW, SD: return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

endpackage

//--- hw/lsu_top.sv
// load/store unit top: issue stage, load and store units and memory arbiter
`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // issue port
    input  logic      lsu_valid_i,
    input  lsu_op_e   op_i,
    input  xlen_t     operand_a_i,
    input  xlen_t     operand_b_i,
    input  xlen_t     imm_i,
    input  trans_id_t trans_id_i,
    output logic      lsu_ready_o,
    // load writeback
    output logic      load_valid_o,
    output trans_id_t load_trans_id_o,
    output xlen_t     load_result_o,
    output logic      load_ex_valid_o,
    output cause_t    load_ex_cause_o,
    output addr_t     load_ex_tval_o,
    // store writeback
    output logic      store_valid_o,
    output trans_id_t store_trans_id_o,
    output xlen_t     store_result_o,
    output logic      store_ex_valid_o,
    output cause_t    store_ex_cause_o,
    output addr_t     store_ex_tval_o,
    // memory port
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output xlen_t     mem_wdata_o,
    output be_t       mem_be_o,
    input  logic      mem_gnt_i,
    input  logic      mem_rvalid_i,
    input  xlen_t     mem_rdata_i
);

    lsu_ctrl_t ctrl;
    logic      ld_valid;
    logic      st_valid;
    logic      pop_ld;
    logic      pop_st;
    addr_t     ld_dw_addr;
    logic      addr_match;

    mem_req_if ld_if ();
    mem_req_if st_if ();

    lsu_issue u_issue (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lsu_valid_i (lsu_valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .trans_id_i  (trans_id_i),
        .pop_ld_i    (pop_ld),
        .pop_st_i    (pop_st),
        .lsu_ready_o (lsu_ready_o),
        .ctrl_o      (ctrl),
        .ld_valid_o  (ld_valid),
        .st_valid_o  (st_valid)
    );

    load_unit u_load (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .valid_i      (ld_valid),
        .ctrl_i       (ctrl),
        .addr_match_i (addr_match),
        .pop_o        (pop_ld),
        .dw_addr_o    (ld_dw_addr),
        .mem          (ld_if.unit_mp),
        .valid_o      (load_valid_o),
        .trans_id_o   (load_trans_id_o),
        .result_o     (load_result_o),
        .ex_valid_o   (load_ex_valid_o),
        .ex_cause_o   (load_ex_cause_o),
        .ex_tval_o    (load_ex_tval_o)
    );

    store_unit u_store (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .valid_i      (st_valid),
        .ctrl_i       (ctrl),
        .dw_addr_i    (ld_dw_addr),
        .pop_o        (pop_st),
        .addr_match_o (addr_match),
        .mem          (st_if.unit_mp),
        .valid_o      (store_valid_o),
        .trans_id_o   (store_trans_id_o),
        .result_o     (store_result_o),
        .ex_valid_o   (store_ex_valid_o),
        .ex_cause_o   (store_ex_cause_o),
        .ex_tval_o    (store_ex_tval_o)
    );

    mem_arbiter u_arb (
        .ld           (ld_if.arb_mp),
        .st           (st_if.arb_mp),
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_be_o     (mem_be_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

//--- hw/mem_arbiter.sv
// memory arbiter: load-first selection of the two units onto one memory port
`timescale 1ns/10ps

module mem_arbiter import lsu_pkg::*; (
    mem_req_if.arb_mp ld,
    mem_req_if.arb_mp st,
    input  logic      clk_i,
    input  logic      rst_ni,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output xlen_t     mem_wdata_o,
    output be_t       mem_be_o,
    input  logic      mem_gnt_i,
    input  logic      mem_rvalid_i,
    input  xlen_t     mem_rdata_i
);

    // last grant was a read, so the response belongs to the load unit
    logic rd_q;

    // ----------------------------------------
    // request path
    // ----------------------------------------
    assign mem_req_o   = ld.req | st.req;
    assign mem_we_o    = ld.req ? ld.we    : st.we;
    assign mem_addr_o  = ld.req ? ld.addr  : st.addr;
    assign mem_wdata_o = ld.req ? ld.wdata : st.wdata;
    assign mem_be_o    = ld.req ? ld.be    : st.be;

    assign ld.gnt = mem_gnt_i & ld.req;
    assign st.gnt = mem_gnt_i & st.req & ~ld.req;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= mem_req_o & mem_gnt_i & ~mem_we_o;
        end
    end

    // ----------------------------------------
    // response path
    // ----------------------------------------
    assign ld.rvalid = mem_rvalid_i & rd_q;
    assign ld.rdata  = mem_rdata_i;
    assign st.rvalid = mem_rvalid_i & ~rd_q;
    assign st.rdata  = mem_rdata_i;

endmodule

//--- hw/mem_req_if.sv
// memory request bundle between one lsu unit and the memory arbiter
`timescale 1ns/10ps

interface mem_req_if import lsu_pkg::*; ();

    // request side, held stable until gnt
    logic  req;
    logic  we;
    addr_t addr;
    xlen_t wdata;
    be_t   be;

    // response side
    logic  gnt;
    logic  rvalid;
    xlen_t rdata;

    modport unit_mp (
        output req, we, addr, wdata, be,
        input  gnt, rvalid, rdata
    );

    modport arb_mp (
        input  req, we, addr, wdata, be,
        output gnt, rvalid, rdata
    );

endinterface

//--- hw/store_unit.sv
// store unit: single outstanding store with lane alignment, memory write and address match
`timescale 1ns/10ps

module store_unit import lsu_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             valid_i,
    input  lsu_ctrl_t        ctrl_i,
    input  addr_t            dw_addr_i,
    output logic             pop_o,
    output logic             addr_match_o,
    mem_req_if.unit_mp       mem,
    output logic             valid_o,
    output trans_id_t        trans_id_o,
    output xlen_t            result_o,
    output logic             ex_valid_o,
    output cause_t           ex_cause_o,
    output addr_t            ex_tval_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        DONE
    } st_state_e;

    st_state_e state_q;
    st_state_e state_d;
    lsu_ctrl_t st_q;
    logic      take;

    assign take  = valid_i && (state_q == IDLE);
    assign pop_o = take;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (take) state_d = ctrl_i.misaligned ? DONE : WAIT_GNT;
            WAIT_GNT: if (mem.gnt) state_d = DONE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            st_q <= ctrl_i;
        end
    end

    // ----------------------------------------
    // memory write
    // ----------------------------------------
    assign mem.req   = (state_q == WAIT_GNT);
    assign mem.we    = 1'b1;
    assign mem.addr  = {st_q.addr[ADDR_W-1:DW_OFF_W], {DW_OFF_W{1'b0}}};
    // data moves up into the lanes selected by be
    assign mem.wdata = st_q.data << {st_q.addr[DW_OFF_W-1:0], 3'b000};
    assign mem.be    = st_q.be;

    // a load to this doubleword has to wait until the write is granted
    assign addr_match_o = (state_q == WAIT_GNT) && !mem.gnt
                          && (st_q.addr[ADDR_W-1:DW_OFF_W] == dw_addr_i[ADDR_W-1:DW_OFF_W]);

    // writeback
    assign valid_o    = (state_q == DONE);
    assign trans_id_o = st_q.trans_id;
    assign result_o   = '0;
    assign ex_valid_o = (state_q == DONE) && st_q.misaligned;
    assign ex_cause_o = CAUSE_ST_MISALIGNED;
    assign ex_tval_o  = st_q.addr;

endmodule
